// File: Makefile
VERILATOR  = verilator
FILELIST   = fetch_frontend.f
TB_TOP     = tb_fetch_frontend
RTL_TOP    = fetch_frontend
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = test failed
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fetch_frontend.f
verilog/fetch_pkg.sv
verilog/redirect_target.sv
verilog/fetch_pc_counter.sv
verilog/fetch_ctrl_fsm.sv
verilog/fetch_stage_pipe.sv
verilog/fetch_frontend.sv
verification/tb_clock_gen.sv
verification/tb_fetch_frontend.sv

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int P_PERIOD       = 40,
  parameter int P_RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(P_PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (P_RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);  // release away from the active edge
    o_reset_n = 1'b1;
  end

endmodule

// File: verification/tb_fetch_frontend.sv
`timescale 1ns/1ns

module tb_fetch_frontend;

  localparam int                CLK_PERIOD  = 40;
  localparam fetch_pkg::vaddr_t PC_INIT     = 39'h00_8000_0000;
  localparam int                FETCH_BYTES = 16;
  localparam fetch_pkg::vaddr_t LINE_BYTES  = fetch_pkg::vaddr_t'(FETCH_BYTES);
  localparam int                RUN_CYCLES  = 4000;
  localparam int                WAIT_LIMIT  = 200;

  logic                     clk;
  logic                     reset_n;
  fetch_pkg::commit_flush_t commit;
  fetch_pkg::br_redirect_t  br;
  fetch_pkg::csr_vec_t      csr;
  logic                     ic_ready;
  fetch_pkg::ic_resp_t      ic_resp;
  logic                     ibuf_ready;
  fetch_pkg::fetch_req_t    fetch_req;
  fetch_pkg::ibuf_load_t    ibuf_load;

  // cache model and s1/s2 shadow
  logic s1_valid;
  logic s2_valid;
  logic s2_live;        // not cleared by flush, miss or stall
  int   ready_hold;     // refill cycles left
  logic miss_pending;
  logic stall_pending;
  logic quiet;          // drain phase

  // scoreboard
  fetch_pkg::vaddr_t exp_deliv;
  fetch_pkg::vaddr_t chain_addr;
  logic              chain_valid;
  logic              first_req_seen;
  logic              timed_out;
  int                error_count;
  int                check_count;
  int                flush_count;
  int                miss_count;
  int                stall_count;
  int                deliver_count;

  tb_clock_gen #(
    .P_PERIOD       (CLK_PERIOD),
    .P_RESET_CYCLES (10)
  ) u_clock_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  fetch_frontend #(
    .P_PC_INIT     (PC_INIT),
    .P_FETCH_BYTES (FETCH_BYTES)
  ) uut (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_commit     (commit),
    .i_br         (br),
    .i_csr        (csr),
    .i_ic_ready   (ic_ready),
    .i_ic_resp    (ic_resp),
    .i_ibuf_ready (ibuf_ready),
    .o_fetch_req  (fetch_req),
    .o_ibuf_load  (ibuf_load)
  );

  // ==================================================
  // reference rules
  // ==================================================

  function automatic fetch_pkg::vaddr_t line_align(input fetch_pkg::vaddr_t addr);
    return addr & ~(LINE_BYTES - fetch_pkg::vaddr_t'(1));
  endfunction

  function automatic fetch_pkg::vaddr_t rand_vaddr();
    return fetch_pkg::vaddr_t'({$urandom, $urandom});
  endfunction

  function automatic fetch_pkg::vaddr_t redirect_addr(input fetch_pkg::commit_flush_t c,
                                                      input fetch_pkg::br_redirect_t b,
                                                      input fetch_pkg::csr_vec_t v);
    fetch_pkg::vaddr_t trap_base;
    trap_base = v.mtvec & ~fetch_pkg::vaddr_t'(1);
    if (!c.valid) return b.target;  // commit wins over branch
    case (c.kind)
      fetch_pkg::SILENT_FLUSH: return c.epc + fetch_pkg::vaddr_t'(4);
      fetch_pkg::REPLAY_FLUSH: return c.epc;
      fetch_pkg::MRET_FLUSH:   return v.mepc;
      fetch_pkg::TRAP_FLUSH:   return trap_base;
      default:                 return trap_base + (fetch_pkg::vaddr_t'(c.int_cause) << 2);
    endcase
  endfunction

  task automatic check_addr(input string what, input fetch_pkg::vaddr_t got,
                            input fetch_pkg::vaddr_t exp);
    check_count++;
    assert (got == exp) else begin
      error_count++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_low(input string what, input logic level);
    check_count++;
    assert (!level) else begin
      error_count++;
      $display("error %0t: %s is high", $time, what);
    end
  endtask

  // ==================================================
  // per-cycle stimulus and checking
  // ==================================================

  task drive_inputs();
    int unsigned pick;
    commit = '0;
    br     = '0;
    ic_resp.valid = s2_valid;  // answer two cycles after accept
    ic_resp.miss  = s2_valid & !quiet & ($urandom_range(7, 0) == 0);
    if (ready_hold > 0) begin
      ic_ready = 1'b0;
      ready_hold--;
    end else begin
      ic_ready = quiet | ($urandom_range(7, 0) != 0);
    end
    ibuf_ready = quiet | ($urandom_range(3, 0) != 0);
    if (first_req_seen && !quiet && $urandom_range(15, 0) == 0) begin
      pick             = $urandom_range(2, 0);  // commit, branch or both
      csr.mtvec        = rand_vaddr();
      csr.mepc         = rand_vaddr();
      commit.valid     = (pick != 1);
      commit.kind      = fetch_pkg::flush_kind_t'($urandom_range(4, 0));
      commit.epc       = rand_vaddr() & ~fetch_pkg::vaddr_t'(3);
      commit.int_cause = fetch_pkg::int_cause_t'($urandom);
      br.valid         = (pick != 0);
      br.target        = rand_vaddr();
    end
  endtask

  task sample_and_check();
    logic              accept;
    logic              stall;
    logic              flush;
    logic              eff_miss;
    fetch_pkg::vaddr_t tgt;
    accept   = fetch_req.valid & ic_ready;
    stall    = ibuf_load.valid & ~ibuf_ready;
    flush    = commit.valid | br.valid;
    eff_miss = s2_valid & s2_live & ic_resp.miss;
    tgt      = redirect_addr(commit, br, csr);

    if (accept) begin
      if (!first_req_seen) begin
        check_addr("first request", fetch_req.vaddr, PC_INIT);
      end else if (flush) begin
        check_addr("redirect request", fetch_req.vaddr, tgt);
      end else if (chain_valid) begin
        check_addr("sequential request", fetch_req.vaddr, line_align(chain_addr) + LINE_BYTES);
      end
    end
    if (ibuf_load.valid && ibuf_ready) begin
      check_addr("delivered line", ibuf_load.vaddr, exp_deliv);
      exp_deliv = exp_deliv + LINE_BYTES;
      deliver_count++;
    end
    if (miss_pending) check_low("ibuf load during miss", ibuf_load.valid);
    if (stall_pending) check_low("ibuf load during buffer stall", ibuf_load.valid);

    if (flush) begin
      flush_count++;
      exp_deliv     = line_align(tgt);  // everything older is dropped
      chain_valid   = accept;
      chain_addr    = tgt;
      miss_pending  = 1'b0;
      stall_pending = 1'b0;
    end else begin
      if (eff_miss) begin
        miss_pending = 1'b1;
        miss_count++;
      end
      if (stall) begin
        stall_pending = 1'b1;
        stall_count++;
      end
      if (accept) begin
        miss_pending  = 1'b0;  // wake-up issues the replay
        stall_pending = 1'b0;
        chain_valid   = 1'b1;
        chain_addr    = fetch_req.vaddr;
      end else if (eff_miss || stall) begin
        chain_valid = 1'b0;
      end
    end

    first_req_seen = first_req_seen | accept;
    if (ic_resp.miss) ready_hold = $urandom_range(6, 1);
    s2_live  = s1_valid & ~(flush | eff_miss | stall);
    s2_valid = s1_valid;
    s1_valid = accept;
  endtask

  task run_cycle();
    @(negedge clk);
    drive_inputs();
    #(CLK_PERIOD / 4);  // outputs settled, well before the rising edge
    sample_and_check();
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    int waited;
    int deliver_goal;
    void'($urandom(32'hf2ca_709f));
    commit         = '0;
    br             = '0;
    csr            = '0;
    ic_ready       = 1'b1;
    ic_resp        = '0;
    ibuf_ready     = 1'b1;
    s1_valid       = 1'b0;
    s2_valid       = 1'b0;
    s2_live        = 1'b0;
    ready_hold     = 0;
    miss_pending   = 1'b0;
    stall_pending  = 1'b0;
    quiet          = 1'b0;
    exp_deliv      = PC_INIT;
    chain_addr     = '0;
    chain_valid    = 1'b0;
    first_req_seen = 1'b0;
    timed_out      = 1'b0;
    error_count    = 0;
    check_count    = 0;
    flush_count    = 0;
    miss_count     = 0;
    stall_count    = 0;
    deliver_count  = 0;

    // reset and the INIT cycle
    waited = 0;
    while (reset_n !== 1'b1 && !timed_out) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      check_low("fetch request valid around reset", fetch_req.valid);
      check_low("ibuf load valid around reset", ibuf_load.valid);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: reset was never released");
      end
    end

    if (!timed_out) begin
      repeat (RUN_CYCLES) run_cycle();
      quiet        = 1'b1;  // no flushes, misses or back-pressure
      deliver_goal = deliver_count + 8;
      waited       = 0;
      while (deliver_count < deliver_goal && !timed_out) begin
        run_cycle();
        waited++;
        if (waited > WAIT_LIMIT) begin
          timed_out = 1'b1;
          $display("timeout: no lines delivered while draining");
        end
      end
    end

    $display("checks %0d, errors %0d, flushes %0d, misses %0d, stalls %0d, lines %0d",
             check_count, error_count, flush_count, miss_count, stall_count, deliver_count);
    if (timed_out || error_count != 0) begin
      $display("test failed");
    end else begin
      $display("test passed");
    end
    $finish;
  end

endmodule

// File: verilog/fetch_ctrl_fsm.sv
`timescale 1ns/1ns

module fetch_ctrl_fsm (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_flush,
  input  logic                    i_ic_ready,
  input  logic                    i_ibuf_ready,
  input  logic                    i_s2_miss,
  input  logic                    i_s2_stall,
  output fetch_pkg::fetch_state_t o_state,
  output logic                    o_req_valid,
  output logic                    o_load,
  output logic                    o_advance,
  output logic                    o_use_flush,
  output logic                    o_use_s2
);

  fetch_pkg::fetch_state_t r_state;
  fetch_pkg::fetch_state_t w_state_next;
  logic                    w_wake;
  logic                    w_load;
  logic                    w_use_s2;

  // ==================================================
  // wake-up per state
  // ==================================================

  always_comb begin
    case (r_state)
      fetch_pkg::WAIT_IBUF_FREE: w_wake = i_ic_ready & i_ibuf_ready;
      default:                   w_wake = i_ic_ready;
    endcase
  end

  // ==================================================
  // next state and pc control
  // ==================================================

  always_comb begin
    w_state_next = r_state;
    w_load       = 1'b0;
    w_use_s2     = 1'b0;

    case (r_state)
      fetch_pkg::INIT: begin
        w_state_next = fetch_pkg::FETCH_REQ;
      end
      fetch_pkg::FETCH_REQ: begin
        if (i_flush) begin
          // redirect goes out now if the cache takes it
          if (!w_wake) begin
            w_load       = 1'b1;
            w_state_next = fetch_pkg::WAIT_FLUSH_FREE;
          end
        end else if (i_s2_miss) begin
          w_load       = 1'b1;
          w_use_s2     = 1'b1;  // refetch the missed line
          w_state_next = fetch_pkg::WAIT_IC_FILL;
        end else if (i_s2_stall) begin
          w_load       = 1'b1;
          w_use_s2     = 1'b1;
          w_state_next = fetch_pkg::WAIT_IBUF_FREE;
        end
      end
      fetch_pkg::WAIT_IC_FILL,
      fetch_pkg::WAIT_IBUF_FREE,
      fetch_pkg::WAIT_FLUSH_FREE: begin
        if (i_flush) begin
          w_load       = !w_wake;  // hold target until wake-up
          w_state_next = w_wake ? fetch_pkg::FETCH_REQ : fetch_pkg::WAIT_FLUSH_FREE;
        end else if (w_wake) begin
          w_state_next = fetch_pkg::FETCH_REQ;
        end
      end
      default: begin
        w_state_next = fetch_pkg::INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= fetch_pkg::INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  // request only when fetch continues next cycle
  assign o_req_valid = (r_state != fetch_pkg::INIT) & (w_state_next == fetch_pkg::FETCH_REQ);
  assign o_advance   = o_req_valid & i_ic_ready;  // accepted request
  assign o_load      = w_load;
  assign o_use_flush = i_flush & (r_state != fetch_pkg::INIT);
  assign o_use_s2    = w_use_s2;
  assign o_state     = r_state;

endmodule

// File: verilog/fetch_frontend.sv
`timescale 1ns/1ns

module fetch_frontend #(
  parameter fetch_pkg::vaddr_t P_PC_INIT     = 39'h00_8000_0000,
  parameter int                P_FETCH_BYTES = 16
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  fetch_pkg::commit_flush_t i_commit,
  input  fetch_pkg::br_redirect_t  i_br,
  input  fetch_pkg::csr_vec_t      i_csr,
  input  logic                    i_ic_ready,
  input  fetch_pkg::ic_resp_t     i_ic_resp,
  input  logic                    i_ibuf_ready,
  output fetch_pkg::fetch_req_t   o_fetch_req,
  output fetch_pkg::ibuf_load_t   o_ibuf_load
);

  localparam fetch_pkg::vaddr_t LP_LINE_MASK =
    ~(fetch_pkg::vaddr_t'(P_FETCH_BYTES) - fetch_pkg::vaddr_t'(1));

  logic                    w_flush;
  fetch_pkg::vaddr_t       w_target;
  fetch_pkg::vaddr_t       w_pc;
  fetch_pkg::vaddr_t       w_s0_vaddr;
  fetch_pkg::vaddr_t       w_load_vaddr;
  fetch_pkg::vaddr_t       w_s2_vaddr;
  fetch_pkg::fetch_state_t w_state;
  fetch_pkg::fetch_req_t   w_req;
  fetch_pkg::ibuf_load_t   w_ibuf_load;
  logic                    w_req_valid;
  logic                    w_load;
  logic                    w_advance;
  logic                    w_use_flush;
  logic                    w_use_s2;
  logic                    w_s2_miss;
  logic                    w_s2_stall;

  // ==================================================
  // redirect and s0 address
  // ==================================================

  redirect_target u_redirect_target (
    .i_commit (i_commit),
    .i_br     (i_br),
    .i_csr    (i_csr),
    .o_flush  (w_flush),
    .o_target (w_target)
  );

  assign w_s0_vaddr   = w_use_flush ? w_target : w_pc;  // redirect bypasses the pc
  assign w_load_vaddr = w_use_s2 ? w_s2_vaddr : w_target;

  fetch_pc_counter #(
    .P_PC_INIT     (P_PC_INIT),
    .P_FETCH_BYTES (P_FETCH_BYTES)
  ) u_fetch_pc_counter (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_load         (w_load),
    .i_load_vaddr   (w_load_vaddr),
    .i_advance      (w_advance),
    .i_advance_base (w_s0_vaddr),
    .o_pc           (w_pc)
  );

  // ==================================================
  // control and pipe
  // ==================================================

  fetch_ctrl_fsm u_fetch_ctrl_fsm (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_flush),
    .i_ic_ready   (i_ic_ready),
    .i_ibuf_ready (i_ibuf_ready),
    .i_s2_miss    (w_s2_miss),
    .i_s2_stall   (w_s2_stall),
    .o_state      (w_state),
    .o_req_valid  (w_req_valid),
    .o_load       (w_load),
    .o_advance    (w_advance),
    .o_use_flush  (w_use_flush),
    .o_use_s2     (w_use_s2)
  );

  assign w_req.valid = w_req_valid;
  assign w_req.vaddr = w_s0_vaddr;

  fetch_stage_pipe u_fetch_stage_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req        (w_req),
    .i_ic_ready   (i_ic_ready),
    .i_flush      (w_flush),
    .i_state      (w_state),
    .i_ic_resp    (i_ic_resp),
    .i_ibuf_ready (i_ibuf_ready),
    .o_s2_vaddr   (w_s2_vaddr),
    .o_s2_miss    (w_s2_miss),
    .o_s2_stall   (w_s2_stall),
    .o_ibuf_load  (w_ibuf_load)
  );

  assign o_fetch_req = w_req;

  // buffer gets whole line addresses
  assign o_ibuf_load.valid = w_ibuf_load.valid;
  assign o_ibuf_load.vaddr = w_ibuf_load.vaddr & LP_LINE_MASK;

endmodule

// File: verilog/fetch_pc_counter.sv
`timescale 1ns/1ns

module fetch_pc_counter #(
  parameter fetch_pkg::vaddr_t P_PC_INIT     = 39'h00_8000_0000,
  parameter int                P_FETCH_BYTES = 16
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_load,
  input  fetch_pkg::vaddr_t i_load_vaddr,
  input  logic              i_advance,
  input  fetch_pkg::vaddr_t i_advance_base,
  output fetch_pkg::vaddr_t o_pc
);

  localparam fetch_pkg::vaddr_t LP_LINE_BYTES = fetch_pkg::vaddr_t'(P_FETCH_BYTES);
  localparam fetch_pkg::vaddr_t LP_ONE        = fetch_pkg::vaddr_t'(1);
  localparam fetch_pkg::vaddr_t LP_LINE_MASK  = ~(LP_LINE_BYTES - LP_ONE);

  fetch_pkg::vaddr_t r_pc;
  fetch_pkg::vaddr_t w_next_line;

  // start of the following fetch line
  assign w_next_line = (i_advance_base & LP_LINE_MASK) + LP_LINE_BYTES;

  // ==================================================
  // s0 fetch address
  // ==================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pc <= P_PC_INIT;
    end else if (i_load) begin
      r_pc <= i_load_vaddr;  // redirect or replay, kept unaligned
    end else if (i_advance) begin
      r_pc <= w_next_line;
    end
  end

  assign o_pc = r_pc;

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  // ==================================================
  // widths
  // ==================================================

  localparam int VADDR_W     = 39;  // sv39 virtual address
  localparam int INT_CAUSE_W = 4;

  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [INT_CAUSE_W-1:0] int_cause_t;

  // ==================================================
  // enums
  // ==================================================

  typedef enum logic [2:0] {
    INIT            = 3'd0,
    FETCH_REQ       = 3'd1,
    WAIT_IC_FILL    = 3'd2,  // s2 miss, refill in progress
    WAIT_IBUF_FREE  = 3'd3,  // buffer full, replay from s2
    WAIT_FLUSH_FREE = 3'd4   // redirect stored, cache busy
  } fetch_state_t;

  // commit flush kinds
  typedef enum logic [2:0] {
    SILENT_FLUSH = 3'd0,  // resume after epc
    REPLAY_FLUSH = 3'd1,  // re-execute epc
    MRET_FLUSH   = 3'd2,
    TRAP_FLUSH   = 3'd3,
    INT_FLUSH    = 3'd4
  } flush_kind_t;

  // ==================================================
  // structs
  // ==================================================

  typedef struct packed {
    logic        valid;
    flush_kind_t kind;
    vaddr_t      epc;
    int_cause_t  int_cause;  // only for INT_FLUSH
  } commit_flush_t;

  // live mispredict from the branch unit
  typedef struct packed {
    logic   valid;
    vaddr_t target;
  } br_redirect_t;

  typedef struct packed {
    vaddr_t mtvec;
    vaddr_t mepc;
  } csr_vec_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } fetch_req_t;

  // cache answer at s2
  typedef struct packed {
    logic valid;
    logic miss;
  } ic_resp_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ibuf_load_t;

endpackage

// File: verilog/fetch_stage_pipe.sv
`timescale 1ns/1ns

module fetch_stage_pipe (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  fetch_pkg::fetch_req_t   i_req,
  input  logic                    i_ic_ready,
  input  logic                    i_flush,
  input  fetch_pkg::fetch_state_t i_state,
  input  fetch_pkg::ic_resp_t     i_ic_resp,
  input  logic                    i_ibuf_ready,
  output fetch_pkg::vaddr_t       o_s2_vaddr,
  output logic                    o_s2_miss,
  output logic                    o_s2_stall,
  output fetch_pkg::ibuf_load_t   o_ibuf_load
);

  logic              r_s1_valid;
  logic              r_s1_clear;
  fetch_pkg::vaddr_t r_s1_vaddr;
  logic              r_s2_valid;
  logic              r_s2_clear;
  fetch_pkg::vaddr_t r_s2_vaddr;

  logic w_accept;
  logic w_kill;
  logic w_s2_live;
  logic w_in_fetch;

  assign w_accept   = i_req.valid & i_ic_ready;
  assign w_in_fetch = (i_state == fetch_pkg::FETCH_REQ);

  // anything already in flight is dead after these
  assign w_kill = i_flush | o_s2_miss | o_s2_stall;

  // ==================================================
  // s1 / s2 registers
  // ==================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s1_clear <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_clear <= 1'b0;
    end else begin
      r_s1_valid <= w_accept;
      r_s1_clear <= w_kill & ~w_accept;  // a request beside a flush is the new path
      r_s2_valid <= r_s1_valid;
      r_s2_clear <= r_s1_clear | w_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_s1_vaddr <= i_req.vaddr;
    end
    r_s2_vaddr <= r_s1_vaddr;
  end

  // cache still answers cleared lines, mask them here
  assign w_s2_live = r_s2_valid & ~r_s2_clear & i_ic_resp.valid & w_in_fetch;

  assign o_s2_miss  = w_s2_live & i_ic_resp.miss;
  assign o_s2_vaddr = r_s2_vaddr;

  assign o_ibuf_load.valid = w_s2_live & ~i_ic_resp.miss & ~i_flush;
  assign o_ibuf_load.vaddr = r_s2_vaddr;

  assign o_s2_stall = o_ibuf_load.valid & ~i_ibuf_ready;  // replay this line later

endmodule

// File: verilog/redirect_target.sv
`timescale 1ns/1ns

module redirect_target (
  input  fetch_pkg::commit_flush_t i_commit,
  input  fetch_pkg::br_redirect_t  i_br,
  input  fetch_pkg::csr_vec_t      i_csr,
  output logic                     o_flush,
  output fetch_pkg::vaddr_t        o_target
);

  localparam fetch_pkg::vaddr_t LP_INSN_BYTES = 4;

  fetch_pkg::vaddr_t w_trap_base;
  fetch_pkg::vaddr_t w_int_offset;
  fetch_pkg::vaddr_t w_commit_target;

  // ==================================================
  // trap vector
  // ==================================================

  // mtvec low bit is the mode field, not part of the base
  assign w_trap_base = {i_csr.mtvec[fetch_pkg::VADDR_W-1:1], 1'b0};

  // vectored entry, one word per cause
  assign w_int_offset = {{(fetch_pkg::VADDR_W - fetch_pkg::INT_CAUSE_W - 2){1'b0}},
                         i_commit.int_cause, 2'b00};

  // ==================================================
  // commit target by flush kind
  // ==================================================

  always_comb begin
    case (i_commit.kind)
      fetch_pkg::SILENT_FLUSH: begin
        w_commit_target = i_commit.epc + LP_INSN_BYTES;  // skip the flushing insn
      end
      fetch_pkg::REPLAY_FLUSH: begin
        w_commit_target = i_commit.epc;
      end
      fetch_pkg::MRET_FLUSH: begin
        w_commit_target = i_csr.mepc;
      end
      fetch_pkg::TRAP_FLUSH: begin
        w_commit_target = w_trap_base;
      end
      fetch_pkg::INT_FLUSH: begin
        w_commit_target = w_trap_base + w_int_offset;
      end
      default: begin
        w_commit_target = i_commit.epc;  // unknown kind, replay
      end
    endcase
  end

  // one flush decision for the whole frontend
  assign o_flush = i_commit.valid | i_br.valid;

  // commit is always older than a mispredict still in flight
  assign o_target = i_commit.valid ? w_commit_target :
                    i_br.valid     ? i_br.target     :
                    '0;

endmodule
